// File: verilog/routerPkg.sv
`default_nettype none

package routerPkg;

  localparam int numPorts = 5;
  localparam int portWidth = 3;

  // port indices, which also give the priority rotation order.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int idWidth = 3;

  // flit ids are one-hot. A one-flit packet is a lone header.
  localparam logic [idWidth-1:0] flitHeader = 3'b001;
  localparam logic [idWidth-1:0] flitBody = 3'b010;
  localparam logic [idWidth-1:0] flitTail = 3'b100;

  localparam int flitWidth = 32;

  // the packet length sits in the low bits of the header data and counts every flit.
  localparam int lenWidth = 12;

  localparam int bufDepth = 16;

  localparam int stateWidth = 6;

  // one-hot arbiter states; bit 0 is idle, bits 1 to 5 follow port order.
  localparam logic [stateWidth-1:0] stateIdle = 6'b000001;
  localparam logic [stateWidth-1:0] stateL = 6'b000010;
  localparam logic [stateWidth-1:0] stateN = 6'b000100;
  localparam logic [stateWidth-1:0] stateE = 6'b001000;
  localparam logic [stateWidth-1:0] stateW = 6'b010000;
  localparam logic [stateWidth-1:0] stateS = 6'b100000;

endpackage

`default_nettype wire

// File: verilog/packetTimer.sv
`timescale 1ns/10ps
`default_nettype none

module packetTimer
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::idWidth-1:0] headId,
  input  logic [routerPkg::lenWidth-1:0] length,
  input  logic runTimer,
  output logic timesUp
);
  import routerPkg::*;

  logic [lenWidth-1:0] latchedLength;
  logic [lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      latchedLength <= '0;
      count <= '0;
    end
    else
    begin
      // a header at the head carries the length of the packet about to be served.
      if (headId == flitHeader)
        latchedLength <= length;
      if (!runTimer)
        count <= '0;
      else
        count <= count + 1'b1;
    end
  end

  assign timesUp = (count == latchedLength);

  // the arbiter must release the port before the count runs past the packet.
  assert property (@(posedge clk) disable iff (rst) runTimer |-> count <= latchedLength)
    else $error("packet timer ran past its latched length");

endmodule

`default_nettype wire

// File: verilog/switchArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module switchArbiter
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] req,
  input  logic [routerPkg::numPorts-1:0][routerPkg::idWidth-1:0] headId,
  input  logic [routerPkg::numPorts-1:0][routerPkg::lenWidth-1:0] headLength,
  output logic [routerPkg::numPorts-1:0] grant,
  output logic [routerPkg::numPorts-1:0] forward
);
  import routerPkg::*;

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  function automatic logic [stateWidth-1:0] portState(input int port);
    case (port)
      portL: portState = stateL;
      portN: portState = stateN;
      portE: portState = stateE;
      portW: portState = stateW;
      portS: portState = stateS;
      default: portState = stateIdle;
    endcase
  endfunction

  // scans count ports from first onwards, wrapping around, and returns the state
  // of the first one that requests. With no requester the result is idle.
  function automatic logic [stateWidth-1:0] firstRequest
  (
    input logic [numPorts-1:0] request,
    input int first,
    input int count
  );
    int idx;
    firstRequest = stateIdle;
    for (int k = count - 1; k >= 0; k--)
    begin
      idx = (first + k) % numPorts;
      if (request[idx])
        firstRequest = portState(idx);
    end
  endfunction

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    packetTimer u_packetTimer
    (
      .clk(clk),
      .rst(rst),
      .headId(headId[p]),
      .length(headLength[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateIdle;
    else
      state <= nextState;
  end

  assign grant = state[stateWidth-1:1];

  always_comb
  begin
    runTimer = '0;
    nextState = stateIdle;
    if (state == stateIdle)
    begin
      nextState = firstRequest(req, portL, numPorts);
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (grant[p])
        begin
          // the grant holds for the whole packet, then priority moves past this port.
          if (req[p] && !timesUp[p])
          begin
            runTimer[p] = 1'b1;
            nextState = state;
          end
          else
          begin
            nextState = firstRequest(req, p + 1, numPorts - 1);
          end
        end
      end
    end
  end

  assign forward = runTimer;

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("arbiter state is not one-hot: %b", state);

  // a grant starts at a packet boundary, so the granted head flit is a header.
  for (genvar p = 0; p < numPorts; p++)
  begin : genBoundary
    assert property (@(posedge clk) disable iff (rst)
      $rose(grant[p]) |-> headId[p] == flitHeader)
      else $error("port %0d granted without a header at its head", p);
  end

endmodule

`default_nettype wire

// File: verilog/flitBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module flitBuffer
#(
  parameter int depth = routerPkg::bufDepth
)
(
  input  logic clk,
  input  logic rst,
  input  logic wrValid,
  input  logic [routerPkg::idWidth-1:0] wrId,
  input  logic [routerPkg::flitWidth-1:0] wrData,
  input  logic pop,
  output logic req,
  output logic [routerPkg::idWidth-1:0] headId,
  output logic [routerPkg::flitWidth-1:0] headData
);
  import routerPkg::*;

  localparam int ptrWidth = $clog2(depth);
  localparam int countWidth = $clog2(depth + 1);

  logic [idWidth-1:0] idMem [depth];
  logic [flitWidth-1:0] dataMem [depth];
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [countWidth-1:0] count;
  logic full;
  logic doWrite;
  logic doPop;

  assign full = (count == countWidth'(depth));
  assign req = (count != '0);

  // a write into a full buffer is lost.
  assign doWrite = wrValid && !full;
  assign doPop = pop && req;

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      idMem[wrPtr] <= wrId;
      dataMem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
      if (doWrite && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doWrite)
        count <= count - 1'b1;
    end
  end

  // an empty buffer shows no flit id, so no stale header reaches the timer.
  assign headId = req ? idMem[rdPtr] : '0;
  assign headData = dataMem[rdPtr];

  assert property (@(posedge clk) disable iff (rst) !(wrValid && full))
    else $error("write to a full flit buffer dropped");

  assert property (@(posedge clk) disable iff (rst) !(pop && !req))
    else $error("pop from an empty flit buffer");

endmodule

`default_nettype wire

// File: verilog/outputCrossbar.sv
`timescale 1ns/10ps
`default_nettype none

module outputCrossbar
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] forward,
  input  logic [routerPkg::numPorts-1:0][routerPkg::idWidth-1:0] headId,
  input  logic [routerPkg::numPorts-1:0][routerPkg::flitWidth-1:0] headData,
  output logic [routerPkg::numPorts-1:0] pop,
  output logic outValid,
  output logic [routerPkg::idWidth-1:0] outId,
  output logic [routerPkg::flitWidth-1:0] outData,
  output logic [routerPkg::portWidth-1:0] outPort
);
  import routerPkg::*;

  logic [idWidth-1:0] selId;
  logic [flitWidth-1:0] selData;
  logic [portWidth-1:0] selPort;

  // the flit taken from a buffer is exactly the one being forwarded.
  assign pop = forward;

  always_comb
  begin
    selId = '0;
    selData = '0;
    selPort = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (forward[p])
      begin
        selId = headId[p];
        selData = headData[p];
        selPort = portWidth'(p);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |forward;
  end

  always_ff @(posedge clk)
  begin
    if (|forward)
    begin
      outId <= selId;
      outData <= selData;
      outPort <= selPort;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(forward))
    else $error("more than one input forwarded: %b", forward);

endmodule

`default_nettype wire

// File: verilog/routerOutputPort.sv
`timescale 1ns/10ps
`default_nettype none

module routerOutputPort
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] inValid,
  input  logic [routerPkg::numPorts-1:0][routerPkg::idWidth-1:0] inId,
  input  logic [routerPkg::numPorts-1:0][routerPkg::flitWidth-1:0] inData,
  output logic outValid,
  output logic [routerPkg::idWidth-1:0] outId,
  output logic [routerPkg::flitWidth-1:0] outData,
  output logic [routerPkg::portWidth-1:0] outPort
);
  import routerPkg::*;

  logic [numPorts-1:0] req;
  logic [numPorts-1:0] forward;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0][idWidth-1:0] headId;
  logic [numPorts-1:0][flitWidth-1:0] headData;
  logic [numPorts-1:0][lenWidth-1:0] headLength;

  for (genvar p = 0; p < numPorts; p++)
  begin : genInput
    flitBuffer
    #(
      .depth(bufDepth)
    )
    u_flitBuffer
    (
      .clk(clk),
      .rst(rst),
      .wrValid(inValid[p]),
      .wrId(inId[p]),
      .wrData(inData[p]),
      .pop(pop[p]),
      .req(req[p]),
      .headId(headId[p]),
      .headData(headData[p])
    );

    // the timer reads the length field straight from the head flit.
    assign headLength[p] = headData[p][lenWidth-1:0];
  end

  switchArbiter u_switchArbiter
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .headId(headId),
    .headLength(headLength),
    .grant(),
    .forward(forward)
  );

  outputCrossbar u_outputCrossbar
  (
    .clk(clk),
    .rst(rst),
    .forward(forward),
    .headId(headId),
    .headData(headData),
    .pop(pop),
    .outValid(outValid),
    .outId(outId),
    .outData(outData),
    .outPort(outPort)
  );

endmodule

`default_nettype wire

// File: testbench/tbRouterOutputPort.sv
`timescale 1ns/10ps
`default_nettype none

module tbRouterOutputPort;
  import routerPkg::*;

  logic clk = 1'b0;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0][idWidth-1:0] inId;
  logic [numPorts-1:0][flitWidth-1:0] inData;
  logic outValid;
  logic [idWidth-1:0] outId;
  logic [flitWidth-1:0] outData;
  logic [portWidth-1:0] outPort;

  // write slots per input: valid, id, data. An invalid slot is an idle cycle.
  logic [35:0] wrQ [numPorts][$];
  // packets still waiting for a grant in the reference model.
  logic [34:0] refFlits [numPorts][$];
  int refLen [numPorts][$];
  // expected output flits in arrival order: port, id, data.
  logic [37:0] expQ [$];
  logic [37:0] expected;

  string testName = "reset";
  int lastPort = portS;
  int cycles = 0;
  int cycleLimit = 200;
  int lastOutCycle = 0;
  int totalFlits = 0;
  int checkedFlits = 0;
  int valueErrors = 0;
  int protocolErrors = 0;

  routerOutputPort u_routerOutputPort
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inId(inId),
    .inData(inData),
    .outValid(outValid),
    .outId(outId),
    .outData(outData),
    .outPort(outPort)
  );

  always #2 clk = ~clk;

  // the port after last in L, N, E, W, S order that has a packet waiting.
  // The last port itself comes at the end of the scan.
  function automatic int nextPort(input int last, input logic [numPorts-1:0] pending);
    int idx;
    int found;
    found = -1;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (last + k) % numPorts;
      if (found < 0 && pending[idx])
        found = idx;
    end
    return found;
  endfunction

  function automatic logic [numPorts-1:0] pendingMask();
    logic [numPorts-1:0] mask;
    mask = '0;
    for (int p = 0; p < numPorts; p++)
      mask[p] = (refLen[p].size() != 0);
    return mask;
  endfunction

  task automatic loadPacket(input int port, input int length);
    logic [idWidth-1:0] id;
    logic [flitWidth-1:0] data;
    for (int i = 0; i < length; i++)
    begin
      data = $urandom();
      if (i == 0)
      begin
        id = flitHeader;
        data[lenWidth-1:0] = lenWidth'(length);
      end
      else if (i == length - 1)
        id = flitTail;
      else
        id = flitBody;
      wrQ[port].push_back({1'b1, id, data});
      refFlits[port].push_back({id, data});
    end
    refLen[port].push_back(length);
    totalFlits += length;
    cycleLimit += 2 * length + 2;
  endtask

  task automatic queueGap(input int port, input int slots);
    for (int i = 0; i < slots; i++)
      wrQ[port].push_back('0);
  endtask

  // moves every waiting packet to the expected queue in grant order.
  task automatic predictOrder();
    logic [numPorts-1:0] pending;
    logic [34:0] flit;
    int port;
    int length;
    pending = pendingMask();
    while (pending != '0)
    begin
      port = nextPort(lastPort, pending);
      length = refLen[port].pop_front();
      for (int i = 0; i < length; i++)
      begin
        flit = refFlits[port].pop_front();
        expQ.push_back({portWidth'(port), flit});
      end
      lastPort = port;
      pending = pendingMask();
    end
  endtask

  // all inputs write in parallel, one slot per cycle each.
  task automatic driveStreams();
    logic [35:0] slot;
    bit busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < numPorts; p++)
      begin
        if (wrQ[p].size() != 0)
        begin
          slot = wrQ[p].pop_front();
          inValid[p] = slot[35];
          inId[p] = slot[34:32];
          inData[p] = slot[31:0];
          busy = 1'b1;
        end
        else
          inValid[p] = 1'b0;
      end
    end
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0)
      @(posedge clk);
    // after the last release cycle the arbiter is idle and scans from L again.
    repeat (3) @(negedge clk);
    lastPort = portS;
  endtask

  task automatic runRound();
    predictOrder();
    driveStreams();
    waitDrain();
  endtask

  task automatic testSingle();
    testName = "single";
    loadPacket(portN, 5);
    runRound();
  endtask

  task automatic testContention();
    testName = "contention";
    loadPacket(portL, 5);
    loadPacket(portN, 3);
    loadPacket(portE, 6);
    loadPacket(portW, 2);
    loadPacket(portS, 4);
    runRound();
  endtask

  task automatic testRotation();
    testName = "rotation";
    loadPacket(portE, 16);
    predictOrder();
    // L and W arrive a few cycles later, while East holds the grant.
    queueGap(portL, 3);
    queueGap(portW, 3);
    loadPacket(portL, 3);
    loadPacket(portW, 4);
    predictOrder();
    driveStreams();
    waitDrain();
  endtask

  task automatic testEdgeLengths();
    testName = "short";
    for (int p = 0; p < numPorts; p++)
      loadPacket(p, 1);
    loadPacket(portN, 1);
    loadPacket(portW, 1);
    runRound();
    testName = "deep";
    loadPacket(portL, bufDepth - 1);
    loadPacket(portE, 1);
    loadPacket(portS, bufDepth);
    runRound();
  endtask

  task automatic testRandom(input int rounds);
    logic [numPorts-1:0] mask;
    int count;
    testName = "random";
    for (int r = 0; r < rounds; r++)
    begin
      mask = numPorts'($urandom_range(1, 31));
      for (int p = 0; p < numPorts; p++)
      begin
        if (mask[p])
        begin
          count = $urandom_range(1, 2);
          for (int k = 0; k < count; k++)
            loadPacket(p, $urandom_range(1, 8));
        end
      end
      runRound();
    end
  endtask

  // outputs change on the rising edge and are sampled in the middle of the cycle.
  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      assert (expQ.size() != 0)
      else
      begin
        protocolErrors++;
        $display("test %s: a flit left the output while none was expected", testName);
      end
      if (expQ.size() != 0)
      begin
        expected = expQ.pop_front();
        checkedFlits++;
        assert (outPort == expected[37:35])
        else
        begin
          valueErrors++;
          $display("ERR %s outPort expected %0d actual %0d", testName, expected[37:35], outPort);
        end
        assert (outId == expected[34:32])
        else
        begin
          valueErrors++;
          $display("ERR %s outId expected %b actual %b", testName, expected[34:32], outId);
        end
        assert (outData == expected[31:0])
        else
        begin
          valueErrors++;
          $display("ERR %s outData expected %h actual %h", testName, expected[31:0], outData);
        end
        // flits of one packet leave in consecutive cycles.
        if (expected[34:32] != flitHeader)
        begin
          assert (cycles == lastOutCycle + 1)
          else
          begin
            protocolErrors++;
            $display("test %s: a packet was broken by an idle cycle on the output", testName);
          end
        end
        lastOutCycle = cycles;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycleLimit)
    begin
      $display("timeout: the output did not drain within %0d cycles", cycleLimit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h45b5));
    rst = 1'b1;
    inValid = '0;
    inId = '0;
    inData = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // nothing is written yet, so any strobe here is caught by the comparator.
    repeat (10) @(negedge clk);
    testSingle();
    testContention();
    testRotation();
    testEdgeLengths();
    testRandom(20);
    $display("checked %0d of %0d flits, %0d value errors, %0d protocol errors",
      checkedFlits, totalFlits, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0 && checkedFlits == totalFlits)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/routerPkg.sv
verilog/packetTimer.sv
verilog/switchArbiter.sv
verilog/flitBuffer.sv
verilog/outputCrossbar.sv
verilog/routerOutputPort.sv
testbench/tbRouterOutputPort.sv

// File: Makefile
TOP = tbRouterOutputPort

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
